// ==== Bender.yml ====
package:
  name: cmul

sources:
  # RTL in compile order
  - files:
      - cmul_pkg.sv
      - cmul_core.sv
      - cmul_skid.sv
      - cmul_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - cmul_assert.sv
      - cmul_tb.sv

// ==== build.f ====
cmul_pkg.sv
cmul_core.sv
cmul_skid.sv
cmul_top.sv
cmul_assert.sv
cmul_tb.sv

// ==== cmul_assert.sv ====
/* Checks on the cmul_top result stream, attached with bind.
   err_count lets the testbench see how many assertions failed. */

`timescale 1ns/1ns

module cmul_assert (
  input logic            clk,
  input logic            arst_n,
  input logic            out_valid,
  input logic            out_ready,
  input cmul_pkg::prod_t y_re,
  input cmul_pkg::prod_t y_im,
  input logic            ovf_re,
  input logic            ovf_im
);

  int err_count = 0;

  // A stalled result stays put until it is taken
  hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(y_re) && $stable(y_im)
                                && $stable(ovf_re) && $stable(ovf_im))
  else begin
    err_count++;
    $error("result changed or vanished while stalled");
  end

  valid_known_a: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_valid))
  else begin
    err_count++;
    $error("out_valid is unknown");
  end

  data_known_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown({y_re, y_im, ovf_re, ovf_im}))
  else begin
    err_count++;
    $error("result data is unknown while out_valid is high");
  end

  // A flag means the part sits on a limit
  ovf_re_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && ovf_re |-> (y_re == cmul_pkg::PROD_MAX || y_re == cmul_pkg::PROD_MIN))
  else begin
    err_count++;
    $error("ovf_re set but y_re is not a limit");
  end

  ovf_im_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && ovf_im |-> (y_im == cmul_pkg::PROD_MAX || y_im == cmul_pkg::PROD_MIN))
  else begin
    err_count++;
    $error("ovf_im set but y_im is not a limit");
  end

  reset_a: assert property (@(posedge clk) !arst_n |-> !out_valid)
  else begin
    err_count++;
    $error("out_valid high during reset");
  end

endmodule

// ==== cmul_core.sv ====
/* Two-stage complex multiplier: stage 1 holds the four partial products, stage 2 the
   clamped sums and overflow flags. conj_b conjugates the b operand. */

`timescale 1ns/1ns

module cmul_core (
  input  logic            clk,
  input  logic            arst_n,

  // Operand stream
  input  logic            in_valid,
  output logic            in_ready,
  input  cmul_pkg::op_t   a_re,
  input  cmul_pkg::op_t   a_im,
  input  cmul_pkg::op_t   b_re,
  input  cmul_pkg::op_t   b_im,
  input  logic            conj_b,

  // Product stream towards the skid buffer
  output logic            core_valid,
  input  logic            core_ready,
  output cmul_pkg::prod_t core_re,
  output cmul_pkg::prod_t core_im,
  output logic            core_ovf_re,
  output logic            core_ovf_im
);

  // Stage 1 state
  logic            s1_valid;
  logic            s1_conj;
  cmul_pkg::prod_t p_rr;
  cmul_pkg::prod_t p_ii;
  cmul_pkg::prod_t p_ri;
  cmul_pkg::prod_t p_ir;

  // Stage 2 state
  logic            s2_valid;
  cmul_pkg::prod_t s2_re;
  cmul_pkg::prod_t s2_im;
  logic            s2_ovf_re;
  logic            s2_ovf_im;

  // Stall control
  logic            s1_adv;
  logic            s2_adv;

  // Stage 2 combinational results
  cmul_pkg::wide_t sum_re;
  cmul_pkg::wide_t sum_im;
  logic            ovf_re_nxt;
  logic            ovf_im_nxt;

  // Value does not fit in prod_t when the two top bits differ
  function automatic logic does_ovf(input cmul_pkg::wide_t v);
    return v[cmul_pkg::WIDE_W-1] != v[cmul_pkg::WIDE_W-2];
  endfunction

  function automatic cmul_pkg::prod_t clamp(input cmul_pkg::wide_t v);
    cmul_pkg::prod_t res;
    if (does_ovf(v)) begin
      res = v[cmul_pkg::WIDE_W-1] ? cmul_pkg::PROD_MIN : cmul_pkg::PROD_MAX;
    end else begin
      res = v[cmul_pkg::PROD_W-1:0];
    end
    return res;
  endfunction

  // A stage loads when empty or when its item leaves this cycle
  assign s2_adv   = !s2_valid || core_ready;
  assign s1_adv   = !s1_valid || s2_adv;
  assign in_ready = s1_adv;

  // Stage 1 valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_adv) begin
      s1_valid <= in_valid;
    end
  end

  // Partial products, all operands signed so the 36-bit context sign-extends
  always_ff @(posedge clk) begin
    if (s1_adv && in_valid) begin
      p_rr    <= a_re * b_re;
      p_ii    <= a_im * b_im;
      p_ri    <= a_re * b_im;
      p_ir    <= a_im * b_re;
      s1_conj <= conj_b;
    end
  end

  // Exact 37-bit sums, sign of the bi terms flips with conjugation
  always_comb begin
    if (s1_conj) begin
      sum_re = p_rr + p_ii;
      sum_im = p_ir - p_ri;
    end else begin
      sum_re = p_rr - p_ii;
      sum_im = p_ri + p_ir;
    end
    ovf_re_nxt = does_ovf(sum_re);
    ovf_im_nxt = does_ovf(sum_im);
  end

  // Stage 2 valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_adv) begin
      s2_valid <= s1_valid;
    end
  end

  // Clamped parts and their flags
  always_ff @(posedge clk) begin
    if (s2_adv && s1_valid) begin
      s2_re     <= clamp(sum_re);
      s2_im     <= clamp(sum_im);
      s2_ovf_re <= ovf_re_nxt;
      s2_ovf_im <= ovf_im_nxt;
    end
  end

  assign core_valid  = s2_valid;
  assign core_re     = s2_re;
  assign core_im     = s2_im;
  assign core_ovf_re = s2_ovf_re;
  assign core_ovf_im = s2_ovf_im;

endmodule

// ==== cmul_pkg.sv ====
/* Shared widths, vector types and saturation limits for the streaming complex multiplier.
   Operand parts are 18-bit signed; product parts are clamped to 36 bits. */

package cmul_pkg;

  // Part widths
  localparam int OP_W   = 18;
  localparam int PROD_W = 2 * OP_W;
  localparam int WIDE_W = PROD_W + 1;

  // One real or imaginary operand part
  typedef logic signed [OP_W-1:0] op_t;

  // One part of the output product, also a single partial product
  typedef logic signed [PROD_W-1:0] prod_t;

  // Exact sum of two partial products before clamping
  typedef logic signed [WIDE_W-1:0] wide_t;

  // Saturation limits
  localparam prod_t PROD_MAX = {1'b0, {(PROD_W-1){1'b1}}};
  localparam prod_t PROD_MIN = {1'b1, {(PROD_W-1){1'b0}}};

  // Occupancy of the output skid buffer
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    ONE   = 2'd1,
    TWO   = 2'd2
  } core_state_e;

endpackage

// ==== cmul_skid.sv ====
/* Two-entry skid buffer, the head entry drives m_data straight from a register.
   s_ready depends on occupancy only, so no combinational path runs from m_ready. */

`timescale 1ns/1ns

module cmul_skid #(
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              arst_n,

  // Upstream side
  input  logic              s_valid,
  output logic              s_ready,
  input  logic [DATA_W-1:0] s_data,

  // Downstream side
  output logic              m_valid,
  input  logic              m_ready,
  output logic [DATA_W-1:0] m_data
);

  cmul_pkg::core_state_e state;
  cmul_pkg::core_state_e state_nxt;

  // Head is the oldest entry, spare holds the second one
  logic [DATA_W-1:0] head;
  logic [DATA_W-1:0] spare;

  logic push;
  logic pop;

  assign s_ready = (state != cmul_pkg::TWO);
  assign m_valid = (state != cmul_pkg::EMPTY);
  assign m_data  = head;

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  // Occupancy FSM
  always_comb begin
    state_nxt = state;
    case (state)
      cmul_pkg::EMPTY: begin
        if (push) state_nxt = cmul_pkg::ONE;
      end
      cmul_pkg::ONE: begin
        if (push && !pop) begin
          state_nxt = cmul_pkg::TWO;
        end else if (!push && pop) begin
          state_nxt = cmul_pkg::EMPTY;
        end
      end
      cmul_pkg::TWO: begin
        if (pop) state_nxt = cmul_pkg::ONE;
      end
      default: state_nxt = cmul_pkg::EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= cmul_pkg::EMPTY;
    end else begin
      state <= state_nxt;
    end
  end

  // Head only changes when empty, popped, or refilled from the spare
  always_ff @(posedge clk) begin
    case (state)
      cmul_pkg::EMPTY: begin
        if (push) head <= s_data;
      end
      cmul_pkg::ONE: begin
        if (push && pop) begin
          head <= s_data;
        end else if (push) begin
          spare <= s_data;
        end
      end
      cmul_pkg::TWO: begin
        if (pop) head <= spare;
      end
      default: ;
    endcase
  end

endmodule

// ==== cmul_tb.sv ====
/* Testbench for cmul_top. Directed rows run with out_ready high and a fixed 3-edge latency,
   xorshift rows run under random back-pressure. Only positive saturation is reachable. */

`timescale 1ns/1ns

module cmul_tb;

  localparam int N_RANDOM   = 48;
  localparam int WAIT_LIMIT = 200;

  typedef struct {
    cmul_pkg::op_t   a_re;
    cmul_pkg::op_t   a_im;
    cmul_pkg::op_t   b_re;
    cmul_pkg::op_t   b_im;
    logic            conj_b;
    cmul_pkg::prod_t y_re;
    cmul_pkg::prod_t y_im;
    logic            ovf_re;
    logic            ovf_im;
  } row_t;

  logic            clk;
  logic            arst_n;
  logic            in_valid;
  logic            in_ready;
  cmul_pkg::op_t   a_re;
  cmul_pkg::op_t   a_im;
  cmul_pkg::op_t   b_re;
  cmul_pkg::op_t   b_im;
  logic            conj_b;
  logic            out_valid;
  logic            out_ready = 1'b1;
  cmul_pkg::prod_t y_re;
  cmul_pkg::prod_t y_im;
  logic            ovf_re;
  logic            ovf_im;

  row_t        rows[$];
  int          accept_cycle[$];
  int          cycle = 0;
  int          n_directed;
  logic [31:0] rng_state;
  bit          backpressure = 1'b0;
  bit          saw_stall = 1'b0;

  cmul_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .a_re      (a_re),
    .a_im      (a_im),
    .b_re      (b_re),
    .b_im      (b_im),
    .conj_b    (conj_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .y_re      (y_re),
    .y_im      (y_im),
    .ovf_re    (ovf_re),
    .ovf_im    (ovf_im)
  );

  bind cmul_top cmul_assert assert_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .y_re      (y_re),
    .y_im      (y_im),
    .ovf_re    (ovf_re),
    .ovf_im    (ovf_im)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Edge counter, read at falling edges only
  always @(posedge clk) cycle <= cycle + 1;

  // Roughly half the cycles ready while back-pressure runs
  always @(posedge clk) begin
    if (backpressure) begin
      out_ready <= next_rand() > 32'h8000_0000;
    end else begin
      out_ready <= 1'b1;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // A quarter of the picks land on the most negative value, the only way to saturate
  function automatic cmul_pkg::op_t rand_op();
    logic [31:0] r;
    r = next_rand();
    if (r[31:30] == 2'b00) begin
      return {1'b1, 17'd0};
    end
    return r[17:0];
  endfunction

  function automatic cmul_pkg::prod_t saturate(input cmul_pkg::wide_t v, output logic ovf);
    cmul_pkg::prod_t res;
    ovf = 1'b1;
    if (v > cmul_pkg::wide_t'(cmul_pkg::PROD_MAX)) begin
      res = cmul_pkg::PROD_MAX;
    end else if (v < cmul_pkg::wide_t'(cmul_pkg::PROD_MIN)) begin
      res = cmul_pkg::PROD_MIN;
    end else begin
      ovf = 1'b0;
      res = v[35:0];
    end
    return res;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_prod(input cmul_pkg::prod_t got, input cmul_pkg::prod_t exp,
                            input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      stop_on_error($sformatf("error at %0t ns: %s is %0d cycles, expected %0d",
                              $time, what, got, exp));
    end
  endtask

  task automatic add_row(input cmul_pkg::op_t ar, input cmul_pkg::op_t ai,
                         input cmul_pkg::op_t br, input cmul_pkg::op_t bi, input logic cj,
                         input cmul_pkg::prod_t yr, input cmul_pkg::prod_t yi,
                         input logic vr, input logic vi);
    row_t r;
    r = '{ar, ai, br, bi, cj, yr, yi, vr, vi};
    rows.push_back(r);
  endtask

  task automatic add_random_rows(input int count);
    row_t            r;
    cmul_pkg::wide_t re_w;
    cmul_pkg::wide_t im_w;
    logic            vr;
    logic            vi;
    int              k;
    for (k = 0; k < count; k++) begin
      r.a_re   = rand_op();
      r.a_im   = rand_op();
      r.b_re   = rand_op();
      r.b_im   = rand_op();
      r.conj_b = next_rand() > 32'h8000_0000;
      if (r.conj_b) begin
        re_w = cmul_pkg::wide_t'(r.a_re) * cmul_pkg::wide_t'(r.b_re)
             + cmul_pkg::wide_t'(r.a_im) * cmul_pkg::wide_t'(r.b_im);
        im_w = cmul_pkg::wide_t'(r.a_im) * cmul_pkg::wide_t'(r.b_re)
             - cmul_pkg::wide_t'(r.a_re) * cmul_pkg::wide_t'(r.b_im);
      end else begin
        re_w = cmul_pkg::wide_t'(r.a_re) * cmul_pkg::wide_t'(r.b_re)
             - cmul_pkg::wide_t'(r.a_im) * cmul_pkg::wide_t'(r.b_im);
        im_w = cmul_pkg::wide_t'(r.a_re) * cmul_pkg::wide_t'(r.b_im)
             + cmul_pkg::wide_t'(r.a_im) * cmul_pkg::wide_t'(r.b_re);
      end
      r.y_re   = saturate(re_w, vr);
      r.y_im   = saturate(im_w, vi);
      r.ovf_re = vr;
      r.ovf_im = vi;
      rows.push_back(r);
    end
  endtask

  // Each row is held until in_ready, the accept cycle is logged for the latency check
  task automatic drive_rows(input int lo, input int hi);
    int i;
    int waited;
    for (i = lo; i < hi; i++) begin
      in_valid <= 1'b1;
      a_re     <= rows[i].a_re;
      a_im     <= rows[i].a_im;
      b_re     <= rows[i].b_re;
      b_im     <= rows[i].b_im;
      conj_b   <= rows[i].conj_b;
      waited = 0;
      @(negedge clk);
      while (!in_ready) begin
        saw_stall = 1'b1;
        waited++;
        if (waited > WAIT_LIMIT) begin
          stop_on_error($sformatf("timeout: input row %0d was never accepted", i));
        end
        @(negedge clk);
      end
      accept_cycle.push_back(cycle);
      @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  task automatic collect_rows(input int lo, input int hi, input bit timed);
    int i;
    int waited;
    int acc;
    for (i = lo; i < hi; i++) begin
      waited = 0;
      @(negedge clk);
      while (!(out_valid && out_ready)) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          stop_on_error($sformatf("timeout: result for row %0d never came out", i));
        end
        @(negedge clk);
      end
      acc = accept_cycle.pop_front();
      check_prod(y_re, rows[i].y_re, $sformatf("row %0d y_re", i));
      check_prod(y_im, rows[i].y_im, $sformatf("row %0d y_im", i));
      check_flag(ovf_re, rows[i].ovf_re, $sformatf("row %0d ovf_re", i));
      check_flag(ovf_im, rows[i].ovf_im, $sformatf("row %0d ovf_im", i));
      if (timed) begin
        check_cycles(cycle - acc, 3, $sformatf("row %0d latency", i));
      end
    end
  endtask

  // Nothing may leave once every expected result is out
  task automatic expect_idle();
    repeat (6) begin
      @(negedge clk);
      check_flag(out_valid, 1'b0, "out_valid after the last result");
    end
  endtask

  // A bound assertion failure ends the run at once
  always @(negedge clk) begin
    if (dut_i.assert_i.err_count != 0) begin
      stop_on_error($sformatf("%0d assertion failures were reported",
                              dut_i.assert_i.err_count));
    end
  end

  initial begin
    rng_state = 32'hf67f7de8;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    a_re      = '0;
    a_im      = '0;
    b_re      = '0;
    b_im      = '0;
    conj_b    = 1'b0;

    add_row(0, 0, 0, 0, 1'b0, 0, 0, 1'b0, 1'b0);
    add_row(3, 0, 5, 0, 1'b0, 15, 0, 1'b0, 1'b0);
    add_row(0, 4, 0, 7, 1'b0, -28, 0, 1'b0, 1'b0);
    add_row(2, 3, 4, -5, 1'b0, 23, 2, 1'b0, 1'b0);
    add_row(-7, 6, 9, 2, 1'b0, -75, 40, 1'b0, 1'b0);
    add_row(300, -400, 300, -400, 1'b1, 250000, 0, 1'b0, 1'b0);
    add_row(2, 3, 4, -5, 1'b1, -7, 22, 1'b0, 1'b0);
    add_row(-131072, -131072, -131072, -131072, 1'b0, 0, cmul_pkg::PROD_MAX, 1'b0, 1'b1);
    add_row(-131072, -131072, -131072, -131072, 1'b1, cmul_pkg::PROD_MAX, 0, 1'b1, 1'b0);
    // Just below the limit, no flag
    add_row(-131072, -131072, -131072, 131071, 1'b0, 36'sd34359607296, 131072, 1'b0, 1'b0);
    n_directed = rows.size();
    add_random_rows(N_RANDOM);

    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");

    @(posedge clk);
    fork
      drive_rows(0, n_directed);
      collect_rows(0, n_directed, 1'b1);
    join
    // Back-to-back accepts with fixed latency mean one result per cycle
    check_flag(saw_stall, 1'b0, "in_ready stall while out_ready was held high");
    expect_idle();

    @(negedge clk);
    backpressure = 1'b1;
    @(posedge clk);
    fork
      drive_rows(n_directed, rows.size());
      collect_rows(n_directed, rows.size(), 1'b0);
    join
    expect_idle();

    if (saw_stall && dut_i.assert_i.err_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else if (!saw_stall) begin
      stop_on_error("in_ready never fell during the back-pressure run");
    end else begin
      stop_on_error($sformatf("%0d assertion failures were reported",
                              dut_i.assert_i.err_count));
    end
  end

endmodule

// ==== cmul_top.sv ====
/* Streaming complex multiplier, three register stages from input to output.
   Output parts saturate to 36 bits with one overflow flag per part. */

`timescale 1ns/1ns

module cmul_top (
  input  logic            clk,
  input  logic            arst_n,

  // Operand stream
  input  logic            in_valid,
  output logic            in_ready,
  input  cmul_pkg::op_t   a_re,
  input  cmul_pkg::op_t   a_im,
  input  cmul_pkg::op_t   b_re,
  input  cmul_pkg::op_t   b_im,
  input  logic            conj_b,

  // Result stream
  output logic            out_valid,
  input  logic            out_ready,
  output cmul_pkg::prod_t y_re,
  output cmul_pkg::prod_t y_im,
  output logic            ovf_re,
  output logic            ovf_im
);

  // Two product parts plus two flags
  localparam int SKID_W = 2 * $bits(cmul_pkg::prod_t) + 2;

  logic              core_valid;
  logic              core_ready;
  cmul_pkg::prod_t   core_re;
  cmul_pkg::prod_t   core_im;
  logic              core_ovf_re;
  logic              core_ovf_im;

  logic [SKID_W-1:0] core_data;
  logic [SKID_W-1:0] skid_data;

  cmul_core core_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .a_re        (a_re),
    .a_im        (a_im),
    .b_re        (b_re),
    .b_im        (b_im),
    .conj_b      (conj_b),
    .core_valid  (core_valid),
    .core_ready  (core_ready),
    .core_re     (core_re),
    .core_im     (core_im),
    .core_ovf_re (core_ovf_re),
    .core_ovf_im (core_ovf_im)
  );

  // Payload layout is flags first, then real, then imaginary
  assign core_data = {core_ovf_re, core_ovf_im, core_re, core_im};

  cmul_skid #(
    .DATA_W (SKID_W)
  ) skid_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (core_valid),
    .s_ready (core_ready),
    .s_data  (core_data),
    .m_valid (out_valid),
    .m_ready (out_ready),
    .m_data  (skid_data)
  );

  assign {ovf_re, ovf_im, y_re, y_im} = skid_data;

endmodule
